//--- hdl/rv_mul_config.svh
// ----------------------------------------
// Multiplier configuration
// Operand width and step counter width
// ----------------------------------------
`ifndef RV_MUL_CONFIG_SVH
`define RV_MUL_CONFIG_SVH

// Operand and result width of 32 or 64
`define XLEN 32

// Wide enough to count up to 64 steps
`define MUL_CNT_W 7

`endif

//--- hdl/rv_mul_pkg.sv
// ----------------------------------------
// Multiplier package
// Data widths, operation codes and FSM states
// ----------------------------------------
`include "rv_mul_config.svh"

package rv_mul_pkg;

  typedef logic [`XLEN-1:0]      xlen_t;
  typedef logic [2*`XLEN-1:0]    dword_t;
  typedef logic [`MUL_CNT_W-1:0] step_cnt_t;

  // Same encoding as funct3 of the M extension
  typedef enum logic [1:0] {
    MUL_LO  = 2'b00,
    MULH_SS = 2'b01,
    MULH_SU = 2'b10,
    MULH_UU = 2'b11
  } mul_op_t;

  typedef enum logic [1:0] {
    S_IDLE    = 2'b00,
    S_COMPUTE = 2'b01,
    S_DONE    = 2'b10
  } mul_state_t;

endpackage

//--- hdl/mul_seq_if.sv
// ----------------------------------------
// Sequencing strobes of the multiplier
// ----------------------------------------
`timescale 1ns/1ps

interface mul_seq_if;

  logic load;
  logic step;
  logic last;
  logic finish;

  modport sequencer (output load, output step, output finish, input last);

  modport counter (input load, input step, output last);

  modport datapath (input load, input step);

  modport result (input load, input finish);

endinterface

//--- hdl/mul_sequencer.sv
// ----------------------------------------
// Multiplier sequencer
// IDLE/COMPUTE/DONE FSM, strobes and busy
// ----------------------------------------
`timescale 1ns/1ps

module mul_sequencer (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       start,
  output logic       busy,
  mul_seq_if.sequencer seq
);

  import rv_mul_pkg::*;

  mul_state_t state;
  mul_state_t state_next;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (start) state_next = S_COMPUTE;
      end
      // Counter tells us when the final step happens
      S_COMPUTE: begin
        if (seq.last) state_next = S_DONE;
      end
      S_DONE: state_next = S_IDLE;
      default: state_next = S_IDLE;
    endcase
  end

  // Start outside IDLE never reaches load
  assign seq.load   = (state == S_IDLE) && start;
  assign seq.step   = (state == S_COMPUTE);
  assign seq.finish = (state == S_DONE);

  assign busy = (state != S_IDLE);

endmodule

//--- hdl/mul_step_counter.sv
// ----------------------------------------
// Step counter
// Counts add-shift steps, flags the last
// ----------------------------------------
`timescale 1ns/1ps
`include "rv_mul_config.svh"

module mul_step_counter (
  input  logic      clk,
  input  logic      reset_n,
  mul_seq_if.counter seq
);

  import rv_mul_pkg::*;

  step_cnt_t count;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count <= '0;
    end else if (seq.load) begin
      count <= '0;
    end else if (seq.step) begin
      count <= count + step_cnt_t'(1);
    end
  end

  // High during step number XLEN counting from one
  assign seq.last = seq.step && (count == step_cnt_t'(`XLEN - 1));

endmodule

//--- hdl/mul_operand_prep.sv
// ----------------------------------------
// Operand conditioner
// Magnitudes of the operands, result sign
// ----------------------------------------
`timescale 1ns/1ps

module mul_operand_prep (
  input  rv_mul_pkg::xlen_t   operand_a,
  input  rv_mul_pkg::xlen_t   operand_b,
  input  rv_mul_pkg::mul_op_t mul_op,
  output rv_mul_pkg::xlen_t   abs_a,
  output rv_mul_pkg::xlen_t   abs_b,
  output logic                negate_result
);

  import rv_mul_pkg::*;

  logic a_signed;
  logic b_signed;
  logic negate_a;
  logic negate_b;

  // MULHSU treats a as signed and b as unsigned
  assign a_signed = (mul_op == MULH_SS) || (mul_op == MULH_SU);
  assign b_signed = (mul_op == MULH_SS);

  assign negate_a = a_signed && operand_a[$bits(xlen_t)-1];
  assign negate_b = b_signed && operand_b[$bits(xlen_t)-1];

  // The most negative value maps onto itself and stays correct as unsigned
  assign abs_a = negate_a ? (~operand_a + xlen_t'(1)) : operand_a;
  assign abs_b = negate_b ? (~operand_b + xlen_t'(1)) : operand_b;

  assign negate_result = negate_a ^ negate_b;

endmodule

//--- hdl/mul_shift_add.sv
// ----------------------------------------
// Shift-add accumulator
// Unsigned product of the two magnitudes
// ----------------------------------------
`timescale 1ns/1ps

module mul_shift_add (
  input  logic               clk,
  input  logic               reset_n,
  input  rv_mul_pkg::xlen_t  abs_a,
  input  rv_mul_pkg::xlen_t  abs_b,
  mul_seq_if.datapath        seq,
  output rv_mul_pkg::dword_t product
);

  import rv_mul_pkg::*;

  dword_t acc;
  dword_t multiplicand;
  xlen_t  multiplier;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      acc          <= '0;
      multiplicand <= '0;
      multiplier   <= '0;
    end else if (seq.load) begin
      acc          <= '0;
      multiplicand <= dword_t'(abs_a);
      multiplier   <= abs_b;
    end else if (seq.step) begin
      // One partial product per step
      if (multiplier[0]) begin
        acc <= acc + multiplicand;
      end
      multiplicand <= multiplicand << 1;
      multiplier   <= multiplier >> 1;
    end
  end

  // Complete after XLEN steps
  assign product = acc;

endmodule

//--- hdl/mul_result_select.sv
// ----------------------------------------
// Result selector
// Applies sign, picks half, pulses ready
// ----------------------------------------
`timescale 1ns/1ps
`include "rv_mul_config.svh"

module mul_result_select (
  input  logic                clk,
  input  logic                reset_n,
  input  rv_mul_pkg::mul_op_t mul_op,
  input  logic                negate_result,
  input  rv_mul_pkg::dword_t  product,
  mul_seq_if.result           seq,
  output rv_mul_pkg::xlen_t   result,
  output logic                ready
);

  import rv_mul_pkg::*;

  mul_op_t op_q;
  logic    negate_q;
  dword_t  signed_product;

  // Operation and sign of the current job
  always_ff @(posedge clk) begin
    if (seq.load) begin
      op_q     <= mul_op;
      negate_q <= negate_result;
    end
  end

  // Negate the whole product so the high half borrows correctly
  assign signed_product = negate_q ? (~product + dword_t'(1)) : product;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result <= '0;
      ready  <= 1'b0;
    end else begin
      ready <= seq.finish;
      if (seq.finish) begin
        if (op_q == MUL_LO) begin
          result <= signed_product[`XLEN-1:0];
        end else begin
          result <= signed_product[2*`XLEN-1:`XLEN];
        end
      end
    end
  end

endmodule

//--- hdl/mul_unit.sv
// ----------------------------------------
// Iterative multiplier, RISC-V M extension
// MUL, MULH, MULHSU and MULHU
// ----------------------------------------
`timescale 1ns/1ps

module mul_unit (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                start,
  input  rv_mul_pkg::mul_op_t mul_op,
  input  rv_mul_pkg::xlen_t   operand_a,
  input  rv_mul_pkg::xlen_t   operand_b,
  output rv_mul_pkg::xlen_t   result,
  output logic                busy,
  output logic                ready
);

  import rv_mul_pkg::*;

  xlen_t  abs_a;
  xlen_t  abs_b;
  logic   negate_result;
  dword_t product;

  mul_seq_if seq_bus ();

  mul_sequencer i_sequencer (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .busy    (busy),
    .seq     (seq_bus)
  );

  mul_step_counter i_step_counter (
    .clk     (clk),
    .reset_n (reset_n),
    .seq     (seq_bus)
  );

  // Combinational, captured downstream on load
  mul_operand_prep i_operand_prep (
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .mul_op        (mul_op),
    .abs_a         (abs_a),
    .abs_b         (abs_b),
    .negate_result (negate_result)
  );

  mul_shift_add i_shift_add (
    .clk     (clk),
    .reset_n (reset_n),
    .abs_a   (abs_a),
    .abs_b   (abs_b),
    .seq     (seq_bus),
    .product (product)
  );

  mul_result_select i_result_select (
    .clk           (clk),
    .reset_n       (reset_n),
    .mul_op        (mul_op),
    .negate_result (negate_result),
    .product       (product),
    .seq           (seq_bus),
    .result        (result),
    .ready         (ready)
  );

endmodule

//--- bench/mul_unit_assert.sv
// ----------------------------------------
// Multiplier protocol assertions
// Ready pulse, busy and reset behavior
// ----------------------------------------
`timescale 1ns/1ps

module mul_unit_assert (
  input logic clk,
  input logic reset_n,
  input logic start,
  input logic busy,
  input logic ready
);

  // Ready is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    ready |=> !ready)
    else $error("ready stayed high for more than one cycle");

  // Busy drops on the same edge that raises ready
  busy_falls_with_ready: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(busy) |-> ready)
    else $error("busy fell without ready");

  ready_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> !busy)
    else $error("busy still high while ready");

  // An accepted start never completes on the next cycle
  no_ready_after_start: assert property (@(posedge clk) disable iff (!reset_n)
    (start && !busy) |=> !ready)
    else $error("ready high in the cycle after start");

  busy_low_in_reset: assert property (@(posedge clk)
    !reset_n |-> !busy)
    else $error("busy high during reset");

endmodule

bind mul_unit mul_unit_assert i_assert (
  .clk     (clk),
  .reset_n (reset_n),
  .start   (start),
  .busy    (busy),
  .ready   (ready)
);

//--- bench/mul_unit_tb.sv
// ----------------------------------------
// Multiplier testbench
// Directed table, LFSR random cases,
// latency and protocol checks
// ----------------------------------------
`timescale 1ns/1ps
`include "rv_mul_config.svh"

module mul_unit_tb;

  import rv_mul_pkg::*;

  typedef struct packed {
    mul_op_t op;
    xlen_t   a;
    xlen_t   b;
    xlen_t   expected;
  } vec_t;

  localparam int    N_DIRECTED  = 15;
  localparam int    N_RANDOM    = 40;
  localparam int    WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * (`XLEN + 6) * 100 + 5 * 100;
  localparam xlen_t X_ONES      = '1;
  localparam xlen_t X_MIN       = {1'b1, {(`XLEN-1){1'b0}}};
  localparam xlen_t X_MAX       = ~X_MIN;

  // Operation, a, b, expected result
  localparam vec_t VECS [0:N_DIRECTED-1] = '{
    '{MUL_LO,  xlen_t'(3),             xlen_t'(7),             xlen_t'(21)},
    '{MUL_LO,  X_ONES,                 X_ONES,                 xlen_t'(1)},
    '{MUL_LO,  X_ONES - xlen_t'(4),    xlen_t'(6),             X_ONES - xlen_t'(29)},
    '{MUL_LO,  X_MIN,                  xlen_t'(2),             xlen_t'(0)},
    '{MUL_LO,  xlen_t'(0),             X_ONES,                 xlen_t'(0)},
    '{MULH_SS, X_ONES - xlen_t'(2),    X_ONES - xlen_t'(4),    xlen_t'(0)},
    '{MULH_SS, X_ONES - xlen_t'(1),    xlen_t'(3),             X_ONES},
    '{MULH_SS, X_MIN,                  X_MIN,                  X_MIN >> 1},
    '{MULH_SS, X_MAX,                  X_MAX,                  (X_MIN >> 1) - xlen_t'(1)},
    '{MULH_SU, X_ONES,                 X_ONES,                 X_ONES},
    '{MULH_SU, X_MIN,                  X_ONES,                 X_MIN},
    '{MULH_SU, xlen_t'(2),             X_ONES,                 xlen_t'(1)},
    '{MULH_UU, X_ONES,                 X_ONES,                 X_ONES - xlen_t'(1)},
    '{MULH_UU, X_ONES,                 xlen_t'(0),             xlen_t'(0)},
    '{MULH_UU, X_MIN,                  xlen_t'(4),             xlen_t'(2)}
  };

  logic        clk;
  logic        reset_n;
  logic        start;
  mul_op_t     mul_op;
  xlen_t       operand_a;
  xlen_t       operand_b;
  xlen_t       result;
  logic        busy;
  logic        ready;
  xlen_t       last_result;
  logic [31:0] lfsr;

  mul_unit i_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .start     (start),
    .mul_op    (mul_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (result),
    .busy      (busy),
    .ready     (ready)
  );

  always #50 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input xlen_t expected, input xlen_t actual);
    stop_on_error($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                            $time, name, expected, actual));
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic draw_word(output xlen_t value);
    value = '0;
    for (int i = 0; i < `XLEN; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[`XLEN-2:0], lfsr[0]};
    end
  endtask

  task automatic draw_op(output mul_op_t op);
    logic [1:0] bits;
    bits = '0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[0], lfsr[0]};
    end
    op = mul_op_t'(bits);
  endtask

  // Each operand is extended by its signedness and multiplied at double width
  function automatic xlen_t ref_mul(input mul_op_t op, input xlen_t a, input xlen_t b);
    logic                      a_signed;
    logic                      b_signed;
    logic signed [2*`XLEN-1:0] ext_a;
    logic signed [2*`XLEN-1:0] ext_b;
    logic signed [2*`XLEN-1:0] sprod;
    logic        [2*`XLEN-1:0] uprod;
    a_signed = (op == MULH_SS) || (op == MULH_SU);
    b_signed = (op == MULH_SS);
    ext_a = a_signed ? {{`XLEN{a[`XLEN-1]}}, a} : {{`XLEN{1'b0}}, a};
    ext_b = b_signed ? {{`XLEN{b[`XLEN-1]}}, b} : {{`XLEN{1'b0}}, b};
    sprod = ext_a * ext_b;
    uprod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    if (op == MULH_UU) return uprod[2*`XLEN-1:`XLEN];
    if (op == MUL_LO) return sprod[`XLEN-1:0];
    return sprod[2*`XLEN-1:`XLEN];
  endfunction

  // One operation with an optional second start mid-flight
  task automatic run_op(input mul_op_t op, input xlen_t a, input xlen_t b,
                        input xlen_t expected, input logic inject);
    int edges;
    @(posedge clk);
    #1;
    start     = 1'b1;
    mul_op    = op;
    operand_a = a;
    operand_b = b;
    // Accepting edge
    @(posedge clk);
    #1;
    start = 1'b0;
    edges = 0;
    @(negedge clk);
    while (ready !== 1'b1 && edges <= `XLEN + 4) begin
      assert (busy === 1'b1) else report_mismatch("busy", xlen_t'(1), xlen_t'(busy));
      assert (result === last_result) else report_mismatch("result", last_result, result);
      @(posedge clk);
      edges++;
      #1;
      if (inject && edges == 4) begin
        start     = 1'b1;
        mul_op    = mul_op_t'(~op);
        operand_a = ~a;
        operand_b = ~b;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
    end
    assert (ready === 1'b1) else stop_on_error("ready never came after start");
    assert (edges == `XLEN + 1)
      else report_mismatch("ready latency", xlen_t'(`XLEN + 1), xlen_t'(edges));
    assert (busy === 1'b0) else report_mismatch("busy", xlen_t'(0), xlen_t'(busy));
    assert (result === expected) else report_mismatch("result", expected, result);
    last_result = expected;
    @(negedge clk);
    assert (ready === 1'b0) else report_mismatch("ready", xlen_t'(0), xlen_t'(ready));
    assert (result === expected) else report_mismatch("result", expected, result);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("Watchdog expired before all operations completed");
  end

  initial begin
    xlen_t   rand_a;
    xlen_t   rand_b;
    mul_op_t rand_op;
    clk         = 1'b0;
    reset_n     = 1'b0;
    start       = 1'b0;
    mul_op      = MUL_LO;
    operand_a   = '0;
    operand_b   = '0;
    last_result = '0;
    lfsr        = 32'hb5b5;
    repeat (5) begin
      @(negedge clk);
      assert (busy === 1'b0) else report_mismatch("busy", xlen_t'(0), xlen_t'(busy));
      assert (ready === 1'b0) else report_mismatch("ready", xlen_t'(0), xlen_t'(ready));
      @(posedge clk);
    end
    #1;
    reset_n = 1'b1;
    @(negedge clk);
    assert (result === '0) else report_mismatch("result", '0, result);

    for (int i = 0; i < N_DIRECTED; i++) begin
      run_op(VECS[i].op, VECS[i].a, VECS[i].b, VECS[i].expected, (i % 2) == 1);
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      draw_word(rand_a);
      draw_word(rand_b);
      draw_op(rand_op);
      run_op(rand_op, rand_a, rand_b, ref_mul(rand_op, rand_a, rand_b), (i % 3) == 0);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
hdl/rv_mul_pkg.sv
hdl/mul_seq_if.sv
hdl/mul_sequencer.sv
hdl/mul_step_counter.sv
hdl/mul_operand_prep.sv
hdl/mul_shift_add.sv
hdl/mul_result_select.sv
hdl/mul_unit.sv
bench/mul_unit_assert.sv
bench/mul_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mul_unit_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
